/* uart_line_pkg.sv */
package uart_line_pkg;

    // serial line levels for an 8N1 frame
    localparam logic LINE_IDLE = 1'b1;
    localparam logic START_BIT = 1'b0;
    localparam logic STOP_BIT  = 1'b1;

    // 50 MHz clock at 115200 baud
    localparam logic [15:0] DEFAULT_CLKS_PER_BIT = 16'd434;
    localparam int unsigned DEFAULT_DATA_BITS    = 8;

    // observable transmitter status, gathered at the top
    typedef struct packed {
        logic ready; // controller idle, a strobe will be taken
        logic line;  // current level of the serial output
    } tx_status_t;

endpackage

/* uart_tx_ctrl_pkg.sv */
package uart_tx_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE      = 2'b00,
        LOAD_DATA = 2'b01,
        SEND_DATA = 2'b10
    } tx_state_e;

    // frame register operation
    typedef enum logic [1:0] {
        CLEAR = 2'b00, // fill with idle level, holds while baud_run is high
        SHIFT = 2'b01,
        LOAD  = 2'b10
    } shift_op_e;

    // bit counter operation
    typedef enum logic {
        ZERO      = 1'b0, // clear, holds while baud_run is high
        INCREMENT = 1'b1
    } count_op_e;

    // control word from the FSM to the data modules
    typedef struct packed {
        shift_op_e shift_op;
        count_op_e count_op;
        logic      baud_run; // timer enable, high for the whole frame
    } tx_ctrl_t;

endpackage

/* uart_tx_controller.sv */
`timescale 1ns/100ps

module uart_tx_controller (
    input  logic                       clk,
    input  logic                       reset_b,
    input  logic                       tx_en,
    input  logic                       baud_tick,
    input  logic                       bit_count_reached,
    output uart_tx_ctrl_pkg::tx_ctrl_t ctrl,
    output logic                       tx_ready
);

    uart_tx_ctrl_pkg::tx_state_e current_state;
    uart_tx_ctrl_pkg::tx_state_e next_state;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            current_state <= uart_tx_ctrl_pkg::IDLE;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        ctrl.shift_op = uart_tx_ctrl_pkg::CLEAR;
        ctrl.count_op = uart_tx_ctrl_pkg::ZERO;
        ctrl.baud_run = 1'b0;
        tx_ready      = 1'b0;
        next_state    = uart_tx_ctrl_pkg::IDLE;

        case (current_state)
            uart_tx_ctrl_pkg::IDLE: begin
                tx_ready = 1'b1;
                if (tx_en) begin
                    next_state = uart_tx_ctrl_pkg::LOAD_DATA;
                end else begin
                    next_state = uart_tx_ctrl_pkg::IDLE;
                end
            end
            uart_tx_ctrl_pkg::LOAD_DATA: begin
                ctrl.shift_op = uart_tx_ctrl_pkg::LOAD; // frame captured at the closing edge
                next_state    = uart_tx_ctrl_pkg::SEND_DATA;
            end
            uart_tx_ctrl_pkg::SEND_DATA: begin
                ctrl.baud_run = 1'b1; // CLEAR/ZERO below now mean hold
                if (baud_tick) begin
                    ctrl.shift_op = uart_tx_ctrl_pkg::SHIFT;
                    ctrl.count_op = uart_tx_ctrl_pkg::INCREMENT;
                end
                if (bit_count_reached) begin
                    next_state = uart_tx_ctrl_pkg::IDLE;
                end else begin
                    next_state = uart_tx_ctrl_pkg::SEND_DATA;
                end
            end
            default: begin
                next_state = uart_tx_ctrl_pkg::IDLE; // recover from an illegal code
            end
        endcase
    end

endmodule

/* uart_baud_timer.sv */
`timescale 1ns/100ps

module uart_baud_timer #(
    parameter int unsigned CLKS_PER_BIT = 16
) (
    input  logic                       clk,
    input  logic                       reset_b,
    input  uart_tx_ctrl_pkg::tx_ctrl_t ctrl,
    output logic                       baud_tick
);

    localparam int unsigned CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] PRE_LAST = CNT_W'(CLKS_PER_BIT - 2);

    logic [CNT_W-1:0] clk_cnt;

    // tick is registered one count early so it is high in the wrap cycle,
    // which makes every bit exactly CLKS_PER_BIT cycles long
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            clk_cnt   <= '0;
            baud_tick <= 1'b0;
        end else if (!ctrl.baud_run) begin
            clk_cnt   <= '0;
            baud_tick <= 1'b0;
        end else begin
            if (clk_cnt == LAST_CNT) begin
                clk_cnt <= '0; // wrap
            end else begin
                clk_cnt <= clk_cnt + CNT_W'(1);
            end
            baud_tick <= (clk_cnt == PRE_LAST);
        end
    end

endmodule

/* uart_tx_bit_counter.sv */
`timescale 1ns/100ps

module uart_tx_bit_counter #(
    parameter int unsigned DATA_BITS = 8
) (
    input  logic                       clk,
    input  logic                       reset_b,
    input  uart_tx_ctrl_pkg::tx_ctrl_t ctrl,
    output logic                       bit_count_reached
);

    localparam int unsigned FRAME_BITS = DATA_BITS + 2; // start + data + stop
    localparam int unsigned CNT_W      = $clog2(FRAME_BITS + 1);
    localparam logic [CNT_W-1:0] FRAME_COUNT = CNT_W'(FRAME_BITS);

    logic [CNT_W-1:0] bit_cnt;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            bit_cnt <= '0;
        end else begin
            case (ctrl.count_op)
                uart_tx_ctrl_pkg::INCREMENT: begin
                    bit_cnt <= bit_cnt + CNT_W'(1);
                end
                default: begin
                    if (!ctrl.baud_run) begin
                        bit_cnt <= '0; // cleared while idle, held between ticks
                    end
                end
            endcase
        end
    end

    assign bit_count_reached = (bit_cnt == FRAME_COUNT);

endmodule

/* uart_tx_shift_register.sv */
`timescale 1ns/100ps

module uart_tx_shift_register #(
    parameter int unsigned DATA_BITS = 8
) (
    input  logic                       clk,
    input  logic                       reset_b,
    input  uart_tx_ctrl_pkg::tx_ctrl_t ctrl,
    input  logic [DATA_BITS-1:0]       tx_data,
    output logic                       line
);

    localparam int unsigned FRAME_BITS = DATA_BITS + 2;

    // bit 0 is on the line, the stop bit sits at the top
    logic [FRAME_BITS-1:0] frame_reg;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            frame_reg <= {FRAME_BITS{uart_line_pkg::LINE_IDLE}}; // line high out of reset
        end else begin
            case (ctrl.shift_op)
                uart_tx_ctrl_pkg::LOAD: begin
                    frame_reg <= {uart_line_pkg::STOP_BIT, tx_data, uart_line_pkg::START_BIT};
                end
                uart_tx_ctrl_pkg::SHIFT: begin
                    frame_reg <= {uart_line_pkg::LINE_IDLE, frame_reg[FRAME_BITS-1:1]};
                end
                uart_tx_ctrl_pkg::CLEAR: begin
                    if (!ctrl.baud_run) begin
                        frame_reg <= {FRAME_BITS{uart_line_pkg::LINE_IDLE}};
                    end
                end
                default: begin
                    frame_reg <= {FRAME_BITS{uart_line_pkg::LINE_IDLE}};
                end
            endcase
        end
    end

    assign line = frame_reg[0]; // lsb first

endmodule

/* uart_tx_top.sv */
`timescale 1ns/100ps

module uart_tx_top #(
    parameter int unsigned CLKS_PER_BIT = uart_line_pkg::DEFAULT_CLKS_PER_BIT,
    parameter int unsigned DATA_BITS    = uart_line_pkg::DEFAULT_DATA_BITS
) (
    input  logic                 clk,
    input  logic                 reset_b,
    input  logic                 tx_en,
    input  logic [DATA_BITS-1:0] tx_data,
    output logic                 tx,
    output logic                 tx_ready
);

    uart_tx_ctrl_pkg::tx_ctrl_t ctrl;
    uart_line_pkg::tx_status_t  status;
    logic                       baud_tick;
    logic                       bit_count_reached;

    uart_tx_controller i_controller (
        .clk               (clk),
        .reset_b           (reset_b),
        .tx_en             (tx_en),
        .baud_tick         (baud_tick),
        .bit_count_reached (bit_count_reached),
        .ctrl              (ctrl),
        .tx_ready          (status.ready)
    );

    uart_baud_timer #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_baud_timer (
        .clk       (clk),
        .reset_b   (reset_b),
        .ctrl      (ctrl),
        .baud_tick (baud_tick)
    );

    uart_tx_bit_counter #(
        .DATA_BITS (DATA_BITS)
    ) i_bit_counter (
        .clk               (clk),
        .reset_b           (reset_b),
        .ctrl              (ctrl),
        .bit_count_reached (bit_count_reached)
    );

    uart_tx_shift_register #(
        .DATA_BITS (DATA_BITS)
    ) i_shift_register (
        .clk     (clk),
        .reset_b (reset_b),
        .ctrl    (ctrl),
        .tx_data (tx_data),
        .line    (status.line)
    );

    assign tx       = status.line;
    assign tx_ready = status.ready;

endmodule

/* tb_uart_tx.sv */
`timescale 1ns/100ps

module tb_uart_tx;

    localparam int unsigned CLKS_PER_BIT  = 8;
    localparam int unsigned DATA_BITS     = 8;
    localparam int unsigned FRAME_BITS    = DATA_BITS + 2; // start + data + stop
    localparam int unsigned CLK_PERIOD    = 40;
    localparam int unsigned DRIVE_DELAY   = 2;
    localparam int unsigned RESET_CYCLES  = 3;
    localparam int unsigned EXTRA_GAP_MAX = 3; // random idle cycles added to nonzero gaps

    logic                 clk = 1'b0;
    logic                 reset_b;
    logic                 tx_en;
    logic [DATA_BITS-1:0] tx_data;
    logic                 tx;
    logic                 tx_ready;

    // test table from the data file
    int unsigned data_q[$];
    int unsigned gap_q[$];
    int unsigned busy_q[$];

    logic [DATA_BITS-1:0] expected_q[$]; // accepted words, oldest first
    int unsigned          frames_done;
    int unsigned          timeout_ns;
    logic                 timeout_armed = 1'b0;

    uart_tx_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .DATA_BITS    (DATA_BITS)
    ) i_dut (
        .clk      (clk),
        .reset_b  (reset_b),
        .tx_en    (tx_en),
        .tx_data  (tx_data),
        .tx       (tx),
        .tx_ready (tx_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, msg, actual, expected);
            $display("Verification failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // first low run on the line: start bit plus any leading zero data bits
    function automatic int unsigned start_low_cycles(input logic [DATA_BITS-1:0] data);
        logic [DATA_BITS-1:0] rest;
        int unsigned          zeros;
        int unsigned          idx;
        logic                 seen_one;
        rest     = data;
        zeros    = 0;
        seen_one = 1'b0;
        for (idx = 0; idx < DATA_BITS; idx++) begin
            if (rest[0] == 1'b1) begin
                seen_one = 1'b1;
            end else if (!seen_one) begin
                zeros++;
            end
            rest = rest >> 1;
        end
        return CLKS_PER_BIT * (zeros + 1);
    endfunction

    task automatic read_tests();
        int          fd;
        int          got;
        int unsigned word;
        int unsigned gap;
        int unsigned flag;
        string       text_line;
        fd = $fopen("uart_tx_tests.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the test file uart_tx_tests.txt");
            $display("Verification failed");
            $fatal(1, "missing test file");
        end
        while (!$feof(fd)) begin
            got = $fgets(text_line, fd);
            if (got != 0 && $sscanf(text_line, "%h %h %h", word, gap, flag) == 3) begin
                data_q.push_back(word);
                gap_q.push_back(gap);
                busy_q.push_back(flag);
            end
        end
        $fclose(fd);
        if (data_q.size() == 0) begin
            $display("ERROR: the test file holds no test lines");
            $display("Verification failed");
            $fatal(1, "empty test file");
        end
    endtask

    task automatic arm_watchdog();
        int unsigned max_gap;
        int unsigned idx;
        max_gap = 0;
        for (idx = 0; idx < data_q.size(); idx++) begin
            if (gap_q[idx] > max_gap) begin
                max_gap = gap_q[idx];
            end
        end
        max_gap       = max_gap + EXTRA_GAP_MAX;
        timeout_ns    = $unsigned(data_q.size()) * (12 * CLKS_PER_BIT + max_gap + 10)
                        * CLK_PERIOD * 2;
        timeout_armed = 1'b1;
    endtask

    task automatic step();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic wait_ready();
        while (tx_ready != 1'b1) begin
            step();
        end
    endtask

    task automatic send_strobe(input logic [DATA_BITS-1:0] data);
        tx_en   = 1'b1;
        tx_data = data;
        expected_q.push_back(data);
        step();
        tx_en = 1'b0;
        check_value(32'(tx_ready), 32'(0), "tx_ready low after strobe");
        step(); // word captured at this edge, tx_data free after it
    endtask

    // extra strobe with other data in the middle of the frame, must be dropped
    task automatic busy_strobe(input logic [DATA_BITS-1:0] data);
        repeat (FRAME_BITS * CLKS_PER_BIT / 2) step();
        check_value(32'(tx_ready), 32'(0), "tx_ready low mid-frame");
        tx_en   = 1'b1;
        tx_data = data;
        step();
        tx_en = 1'b0;
        step();
    endtask

    // called at the first falling-edge sample of the start bit
    task automatic receive_frame(output logic [FRAME_BITS-1:0] bits,
                                 output int unsigned low_run);
        int unsigned idx;
        logic        in_low;
        bits    = '1;
        low_run = 0;
        in_low  = 1'b1;
        for (idx = 0; idx < FRAME_BITS * CLKS_PER_BIT; idx++) begin
            if (idx != 0) begin
                @(negedge clk);
            end
            if (in_low && tx == 1'b0) begin
                low_run++;
            end else begin
                in_low = 1'b0;
            end
            check_value(32'(tx_ready), 32'(0), "tx_ready low during frame");
            if (idx % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
                bits = {tx, bits[FRAME_BITS-1:1]}; // lsb arrives first
            end
        end
    endtask

    initial begin : line_monitor
        logic [FRAME_BITS-1:0] bits;
        logic [DATA_BITS-1:0]  expected;
        int unsigned           low_run;
        int unsigned           expected_low;
        logic                  low_ok;
        wait (reset_b == 1'b1);
        forever begin
            @(negedge clk); // tx only moves on rising edges
            if (tx == 1'b0) begin
                check_value(32'(expected_q.size() != 0), 32'(1),
                            "start bit with no frame pending");
                expected = expected_q.pop_front();
                receive_frame(bits, low_run);
                check_value(32'(bits[0]), 32'(0),
                            $sformatf("start bit of frame %0d", frames_done));
                check_value(32'(bits[FRAME_BITS-2:1]), 32'(expected),
                            $sformatf("data bits of frame %0d", frames_done));
                check_value(32'(bits[FRAME_BITS-1]), 32'(1),
                            $sformatf("stop bit of frame %0d", frames_done));
                expected_low = start_low_cycles(expected);
                low_ok = (low_run + 1 >= expected_low) && (low_run <= expected_low + 1);
                check_value(32'(low_ok), 32'(1),
                            $sformatf("start low time %0d cycles in frame %0d",
                                      low_run, frames_done));
                frames_done++;
            end
        end
    end

    always @(negedge clk) begin
        if (reset_b == 1'b1 && tx_ready == 1'b1) begin
            check_value(32'(tx), 32'(1), "tx high while transmitter is ready");
        end
    end

    initial begin : watchdog
        wait (timeout_armed == 1'b1);
        #(timeout_ns);
        $display("ERROR: the transmitter timed out after %0d ns before all frames were sent",
                 timeout_ns);
        $display("Verification failed");
        $fatal(1, "timeout");
    end

    initial begin : stimulus
        int unsigned idx;
        int unsigned extra;
        tx_en       = 1'b0;
        tx_data     = '0;
        reset_b     = 1'b0;
        frames_done = 0;
        void'($urandom(42));
        read_tests();
        arm_watchdog();
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset_b = 1'b1;
        step();
        check_value(32'(tx), 32'(1), "tx high after reset");
        check_value(32'(tx_ready), 32'(1), "tx_ready high after reset");

        for (idx = 0; idx < data_q.size(); idx++) begin
            extra = 0;
            if (gap_q[idx] != 0) begin
                extra = $urandom % (EXTRA_GAP_MAX + 1);
            end
            repeat (gap_q[idx] + extra) step();
            wait_ready(); // gap 0 gives back-to-back frames
            send_strobe(DATA_BITS'(data_q[idx]));
            if (busy_q[idx] != 0) begin
                busy_strobe(~DATA_BITS'(data_q[idx]));
            end
        end

        while (frames_done < data_q.size()) begin
            step();
        end
        wait_ready();
        repeat (CLKS_PER_BIT) step();
        check_value(32'(tx), 32'(1), "tx idle after last frame");

        $display("Verification passed");
        $finish;
    end

endmodule

/* uart_tx_tests.txt */
// uart tx tests, all values hex, one test per line
// columns: data word, idle gap in clock cycles, busy strobe flag (1 = extra strobe mid-frame)
55 0008 0
aa 0000 0
00 0000 0
ff 0000 0
01 0004 0
80 0000 1
fe 0010 0
7f 0000 0
0f 0003 1
f0 0000 0
a5 0000 1
5a 0001 0
c3 0020 0
3c 0000 0
02 0000 0
40 0002 1
10 0007 0
08 0000 0
e7 0000 1
18 0011 0
99 0000 0
66 0005 0
12 0000 1
34 0000 0
56 0001 0
78 0000 0
9a 0018 1
bc 0000 0
de 0000 0
f1 0006 0
04 0000 1
20 0002 0
81 0000 0
b6 000c 0

/* flist.f */
uart_line_pkg.sv
uart_tx_ctrl_pkg.sv
uart_tx_controller.sv
uart_baud_timer.sv
uart_tx_bit_counter.sv
uart_tx_shift_register.sv
uart_tx_top.sv
tb_uart_tx.sv

/* Makefile */
VERILATOR = verilator
TOP       = tb_uart_tx
FLIST     = flist.f
OBJ_DIR   = obj_dir
FLAGS     = --binary --timing --timescale 1ns/100ps -j 0 --Mdir $(OBJ_DIR)

SOURCES   = $(shell cat $(FLIST))
BINARY    = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

# the test file is read at run time from the project root
run: compile
	./$(BINARY)

clean:
	rm -rf $(OBJ_DIR)
